// ==== backing_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module backing_ram #(
	parameter int data_width = 32,
	parameter int ram_words  = 256
) (
	input  logic                         clock,
	input  logic                         ram_read,
	input  logic                         ram_write,
	input  logic [$clog2(ram_words)-1:0] ram_index,
	input  logic [data_width-1:0]        ram_wdata,
	input  logic [data_width/8-1:0]      ram_wmask,
	output logic [data_width-1:0]        ram_rdata
);

	// Word array, aliases across the dtim window
	logic [data_width-1:0] mem [ram_words];

	always_ff @(posedge clock) begin
		if (ram_write) begin
			for (int b = 0; b < data_width / 8; b++) begin
				if (ram_wmask[b])
					mem[ram_index][b*8 +: 8] <= ram_wdata[b*8 +: 8];
			end
		end
		if (ram_read)
			ram_rdata <= mem[ram_index];  // Held until the next read
	end

endmodule

`default_nettype wire

// ==== pma_check.sv ====
`timescale 1ns/1ns
`default_nettype none

module pma_check #(
	parameter int data_width = 32
) (
	input  tl_pkg::addr_t req_address,
	input  tl_pkg::size_t req_size,
	input  logic          req_write,
	output logic          allowed,
	output logic          in_ram
);
	import tl_pkg::*;

	localparam int beat_log2 = $clog2(data_width / 8);

	region_e first_region;
	region_e last_region;
	addr_t   last_address;
	addr_t   align_mask;
	perm_t   perm;
	logic    aligned;

	function automatic region_e region_of(addr_t address);
		region_e found;
		int      i;
		found = region_none;
		for (i = 1; i < region_count; i++) begin
			if (address >= region_base[i] && address < region_limit[i])
				found = region_e'(i);
		end
		return found;
	endfunction

	always_comb begin
		last_address = req_address + (addr_t'(1) << req_size) - addr_t'(1);
		first_region = region_of(req_address);
		last_region  = region_of(last_address);

		// Both ends must grant it
		perm = perm_t'(region_perm[first_region] & region_perm[last_region]);

		// Misalignment only counts inside one beat
		if (req_size > size_t'(beat_log2))
			align_mask = (addr_t'(1) << beat_log2) - addr_t'(1);
		else
			align_mask = (addr_t'(1) << req_size) - addr_t'(1);
		aligned = (req_address & align_mask) == '0;

		allowed = aligned && (req_write ? perm.writable : perm.readable);
		in_ram  = first_region == region_dtim && last_region == region_dtim;
	end

endmodule

`default_nettype wire

// ==== reset_stretch.sv ====
`timescale 1ns/1ns
`default_nettype none

module reset_stretch (
	input  logic clock,
	input  logic reset,
	output logic int_reset
);
	import tl_pkg::*;

	localparam int hold_w = $clog2(reset_hold_cycles + 1);

	logic [hold_w-1:0] hold_count;

	always_ff @(posedge clock) begin
		if (reset)
			hold_count <= hold_w'(reset_hold_cycles);
		else if (hold_count != '0)
			hold_count <= hold_count - 1'b1;
	end

	assign int_reset = reset || hold_count != '0;  // Held past external release

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tl_responder_tb \
	-f tl_responder.f \
	-o sim_tl_responder
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tl_responder)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns    = 100,
	parameter int reset_cycles = 8
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(period_ns / 2) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== tl_pkg.sv ====
`default_nettype none

package tl_pkg;

	localparam int addr_width = 32;

	typedef logic [addr_width-1:0] addr_t;
	typedef logic [2:0] opcode_t;
	typedef logic [3:0] size_t;    // log2 of bytes
	typedef logic [0:0] source_t;

	// A channel
	localparam opcode_t op_put_full    = 3'd0;
	localparam opcode_t op_put_partial = 3'd1;
	localparam opcode_t op_arithmetic  = 3'd2;
	localparam opcode_t op_logical     = 3'd3;
	localparam opcode_t op_get         = 3'd4;
	localparam opcode_t op_intent      = 3'd5;

	// D channel
	localparam opcode_t op_access_ack      = 3'd0;
	localparam opcode_t op_access_ack_data = 3'd1;

	typedef enum logic [2:0] {
		region_none,
		region_debug,
		region_error_dev,
		region_rom,
		region_clint,
		region_plic,
		region_mmio,
		region_dtim
	} region_e;

	typedef struct packed {
		logic readable;
		logic writable;
	} perm_t;

	localparam int    region_count = 8;
	localparam addr_t dtim_base    = 32'h8000_0000;

	localparam perm_t perm_no = '{readable: 1'b0, writable: 1'b0};
	localparam perm_t perm_ro = '{readable: 1'b1, writable: 1'b0};
	localparam perm_t perm_rw = '{readable: 1'b1, writable: 1'b1};

	// Limits are exclusive, entries follow region_e order
	localparam addr_t region_base [region_count] = '{
		32'h0000_0000, 32'h0000_0000, 32'h0000_3000, 32'h0001_0000,
		32'h0200_0000, 32'h0c00_0000, 32'h6000_0000, dtim_base
	};
	localparam addr_t region_limit [region_count] = '{
		32'h0000_0000, 32'h0000_1000, 32'h0000_4000, 32'h0002_0000,
		32'h0201_0000, 32'h1000_0000, 32'h8000_0000, dtim_base + 32'h4000
	};
	localparam perm_t region_perm [region_count] = '{
		perm_no, perm_rw, perm_rw, perm_ro, perm_rw, perm_rw, perm_rw, perm_rw
	};

	localparam int reset_hold_cycles = 5;

endpackage

`default_nettype wire

// ==== tl_responder.f ====
tl_pkg.sv
reset_stretch.sv
pma_check.sv
tl_sequencer.sv
backing_ram.sv
tl_responder.sv
tb_clock_gen.sv
tl_responder_tb.sv

// ==== tl_responder.sv ====
`timescale 1ns/1ns
`default_nettype none

module tl_responder #(
	parameter int data_width = 32,
	parameter int ram_words  = 256
) (
	input  logic                    clock,
	input  logic                    reset,

	output logic                    a_ready,
	input  logic                    a_valid,
	input  tl_pkg::opcode_t         a_opcode,
	input  tl_pkg::size_t           a_size,
	input  tl_pkg::source_t         a_source,
	input  tl_pkg::addr_t           a_address,
	input  logic [data_width/8-1:0] a_mask,
	input  logic [data_width-1:0]   a_data,

	input  logic                    d_ready,
	output logic                    d_valid,
	output tl_pkg::opcode_t         d_opcode,
	output tl_pkg::size_t           d_size,
	output tl_pkg::source_t         d_source,
	output logic                    d_denied,
	output logic                    d_corrupt,
	output logic [data_width-1:0]   d_data
);
	import tl_pkg::*;

	localparam int index_w = $clog2(ram_words);

	logic                    int_reset;
	addr_t                   req_address;
	size_t                   req_size;
	logic                    req_write;
	logic                    allowed;
	logic                    in_ram;
	logic                    ram_read;
	logic                    ram_write;
	logic [index_w-1:0]      ram_index;
	logic [data_width-1:0]   ram_wdata;
	logic [data_width/8-1:0] ram_wmask;
	logic [data_width-1:0]   ram_rdata;

	reset_stretch reset_stretch_i (
		.clock     (clock),
		.reset     (reset),
		.int_reset (int_reset)
	);

	tl_sequencer #(
		.data_width (data_width),
		.ram_words  (ram_words)
	) tl_sequencer_i (
		.clock       (clock),
		.int_reset   (int_reset),
		.a_ready     (a_ready),
		.a_valid     (a_valid),
		.a_opcode    (a_opcode),
		.a_size      (a_size),
		.a_source    (a_source),
		.a_address   (a_address),
		.a_mask      (a_mask),
		.a_data      (a_data),
		.d_ready     (d_ready),
		.d_valid     (d_valid),
		.d_opcode    (d_opcode),
		.d_size      (d_size),
		.d_source    (d_source),
		.d_denied    (d_denied),
		.d_corrupt   (d_corrupt),
		.d_data      (d_data),
		.req_address (req_address),
		.req_size    (req_size),
		.req_write   (req_write),
		.allowed     (allowed),
		.in_ram      (in_ram),
		.ram_read    (ram_read),
		.ram_write   (ram_write),
		.ram_index   (ram_index),
		.ram_wdata   (ram_wdata),
		.ram_wmask   (ram_wmask),
		.ram_rdata   (ram_rdata)
	);

	pma_check #(
		.data_width (data_width)
	) pma_check_i (
		.req_address (req_address),
		.req_size    (req_size),
		.req_write   (req_write),
		.allowed     (allowed),
		.in_ram      (in_ram)
	);

	backing_ram #(
		.data_width (data_width),
		.ram_words  (ram_words)
	) backing_ram_i (
		.clock     (clock),
		.ram_read  (ram_read),
		.ram_write (ram_write),
		.ram_index (ram_index),
		.ram_wdata (ram_wdata),
		.ram_wmask (ram_wmask),
		.ram_rdata (ram_rdata)
	);

endmodule

`default_nettype wire

// ==== tl_responder_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module tl_responder_tb;
	import tl_pkg::*;

	localparam int period_ns     = 100;
	localparam int reset_cycles  = 8;
	localparam int hold_cycles   = 5;
	localparam int request_count = 20;

	typedef struct packed {
		logic [2:0]  opcode;
		logic [3:0]  size;
		logic        source;
		logic        denied;
		logic        corrupt;
		logic [31:0] data;
	} beat_t;

	logic        clock;
	logic        reset;
	logic        a_ready;
	logic        a_valid;
	opcode_t     a_opcode;
	size_t       a_size;
	source_t     a_source;
	addr_t       a_address;
	logic [3:0]  a_mask;
	logic [31:0] a_data;
	logic        d_ready = 1'b0;
	logic        d_valid;
	opcode_t     d_opcode;
	size_t       d_size;
	source_t     d_source;
	logic        d_denied;
	logic        d_corrupt;
	logic [31:0] d_data;

	beat_t       expected [$];
	logic [31:0] shadow [256];  // Word image of dtim
	int          error_count    = 0;
	int          beat_count     = 0;
	int          expected_beats = 0;
	int          edge_count     = 0;
	int          seed           = 20;
	logic        random_ready   = 1'b0;
	logic        source_bit     = 1'b0;
	logic        hold_pending   = 1'b0;
	logic [31:0] rand_word;
	beat_t       seen;
	beat_t       held_beat;
	beat_t       want;

	tb_clock_gen #(
		.period_ns    (period_ns),
		.reset_cycles (reset_cycles)
	) clock_gen_i (
		.clock (clock),
		.reset (reset)
	);

	tl_responder #(
		.data_width (32),
		.ram_words  (256)
	) dut_i (
		.clock     (clock),
		.reset     (reset),
		.a_ready   (a_ready),
		.a_valid   (a_valid),
		.a_opcode  (a_opcode),
		.a_size    (a_size),
		.a_source  (a_source),
		.a_address (a_address),
		.a_mask    (a_mask),
		.a_data    (a_data),
		.d_ready   (d_ready),
		.d_valid   (d_valid),
		.d_opcode  (d_opcode),
		.d_size    (d_size),
		.d_source  (d_source),
		.d_denied  (d_denied),
		.d_corrupt (d_corrupt),
		.d_data    (d_data)
	);

	// Address map with rom as the only read-only region
	function automatic logic region_allows(input logic [31:0] address, input logic write);
		if (address < 32'h0000_1000)
			return 1'b1;
		if (address >= 32'h0000_3000 && address < 32'h0000_4000)
			return 1'b1;
		if (address >= 32'h0001_0000 && address < 32'h0002_0000)
			return !write;
		if (address >= 32'h0200_0000 && address < 32'h0201_0000)
			return 1'b1;
		if (address >= 32'h0c00_0000 && address < 32'h1000_0000)
			return 1'b1;
		return address >= 32'h6000_0000 && address < 32'h8000_4000;  // mmio and dtim
	endfunction

	function automatic logic in_dtim(input logic [31:0] address);
		return address >= 32'h8000_0000 && address < 32'h8000_4000;
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp_value);
		assert (got == exp_value) else begin
			$display("Error at %0t: %s = %h, expected %h", $time, name, got, exp_value);
			error_count++;
		end
	endtask

	// Queues the expected beats, then holds the request until accepted
	task automatic issue(input opcode_t opcode, input size_t size, input logic [31:0] address,
		input logic [3:0] mask, input logic [31:0] data);
		logic [31:0] last_byte;
		logic [31:0] word_addr;
		logic        write;
		logic        permitted;
		logic        ram_hit;
		int          beats;
		beat_t       beat;
		write     = opcode == op_put_full;
		last_byte = address + (32'd1 << size) - 32'd1;
		permitted = region_allows(address, write) && region_allows(last_byte, write)
			&& (address & ((32'd1 << size) - 32'd1)) == 32'd0;
		ram_hit   = in_dtim(address) && in_dtim(last_byte);
		beat      = '{opcode: op_access_ack, size: size, source: source_bit,
			denied: 1'b1, corrupt: 1'b0, data: 32'd0};
		beats     = 1;
		if (opcode == op_get) begin
			beat.opcode  = op_access_ack_data;
			beat.denied  = !permitted;
			beat.corrupt = !permitted;
			if (permitted && size > 4'd2)
				beats = 1 << (size - 4'd2);
		end else if (write) begin
			beat.denied = !(permitted && size <= 4'd2);
			if (!beat.denied && ram_hit) begin
				word_addr = address >> 2;
				for (int b = 0; b < 4; b++) begin
					if (mask[b])
						shadow[word_addr[7:0]][b*8 +: 8] = data[b*8 +: 8];
				end
			end
		end
		for (int i = 0; i < beats; i++) begin
			word_addr = (address >> 2) + 32'(i);
			if (opcode == op_get && permitted && ram_hit)
				beat.data = shadow[word_addr[7:0]];
			expected.push_back(beat);
			expected_beats++;
		end
		a_valid   <= 1'b1;
		a_opcode  <= opcode;
		a_size    <= size;
		a_source  <= source_bit;
		a_address <= address;
		a_mask    <= mask;
		a_data    <= data;
		source_bit = !source_bit;
		@(posedge clock);
		while (!a_ready) @(posedge clock);
	endtask

	always @(posedge clock) begin
		rand_word = $random(seed);
		if (reset)
			d_ready <= 1'b0;
		else if (random_ready)
			d_ready <= rand_word[1:0] != 2'b00;  // Ready three times in four
		else
			d_ready <= 1'b1;
	end

	always @(posedge clock) begin
		edge_count = edge_count + 1;
		seen = {d_opcode, d_size, d_source, d_denied, d_corrupt, d_data};
		if (edge_count >= 2 && edge_count <= reset_cycles + hold_cycles) begin
			check_field("a_ready", 32'(a_ready), 32'd0);
			check_field("d_valid", 32'(d_valid), 32'd0);
		end
		if (edge_count == reset_cycles + hold_cycles + 2)
			assert (a_ready) else begin
				$display("a_ready did not rise once the internal reset ended");
				error_count++;
			end
		if (hold_pending)
			assert (d_valid && seen == held_beat) else begin
				$display("Error at %0t: D beat = %h, expected %h held under back-pressure",
					$time, seen, held_beat);
				error_count++;
			end
		if (d_valid && !d_ready)
			check_field("a_ready", 32'(a_ready), 32'd0);
		hold_pending = d_valid && !d_ready;
		held_beat    = seen;
		if (d_valid && d_ready) begin
			beat_count++;
			assert (expected.size() != 0) else begin
				$display("A D beat arrived with no response outstanding");
				error_count++;
			end
			if (expected.size() != 0) begin
				want = expected.pop_front();
				check_field("d_opcode", 32'(d_opcode), 32'(want.opcode));
				check_field("d_size", 32'(d_size), 32'(want.size));
				check_field("d_source", 32'(d_source), 32'(want.source));
				check_field("d_denied", 32'(d_denied), 32'(want.denied));
				check_field("d_corrupt", 32'(d_corrupt), 32'(want.corrupt));
				check_field("d_data", d_data, want.data);
			end
		end
	end

	initial begin
		a_valid   = 1'b0;
		a_opcode  = op_get;
		a_size    = 4'd0;
		a_source  = 1'b0;
		a_address = 32'd0;
		a_mask    = 4'h0;
		a_data    = 32'd0;
		@(posedge clock);
		while (reset) @(posedge clock);
		issue(op_put_full, 4'd2, 32'h8000_0000, 4'hf, 32'h1111_2222);
		issue(op_put_full, 4'd2, 32'h8000_0004, 4'hf, 32'h3333_4444);
		issue(op_put_full, 4'd2, 32'h8000_0008, 4'hf, 32'h5555_6666);
		issue(op_put_full, 4'd2, 32'h8000_000c, 4'hf, 32'h7777_8888);
		issue(op_put_full, 4'd2, 32'h8000_0004, 4'b0110, 32'ha5c3_1e77);
		issue(op_get, 4'd2, 32'h8000_0004, 4'hf, 32'd0);
		issue(op_get, 4'd4, 32'h8000_0000, 4'hf, 32'd0);
		issue(op_put_full, 4'd2, 32'h0001_0000, 4'hf, 32'hdead_beef);  // Rom, same RAM word 0
		issue(op_get, 4'd2, 32'h8000_0000, 4'hf, 32'd0);
		issue(op_get, 4'd2, 32'h4000_0000, 4'hf, 32'd0);  // Unmapped
		issue(op_get, 4'd2, 32'h8000_0002, 4'hf, 32'd0);  // Misaligned
		issue(op_intent, 4'd2, 32'h8000_0000, 4'hf, 32'd0);
		issue(op_arithmetic, 4'd2, 32'h8000_0000, 4'hf, 32'h0000_0001);
		issue(op_get, 4'd2, 32'h0000_0100, 4'hf, 32'd0);  // Debug region
		issue(op_put_full, 4'd3, 32'h8000_0008, 4'hf, 32'hffff_ffff);
		random_ready <= 1'b1;
		issue(op_get, 4'd4, 32'h8000_0000, 4'hf, 32'd0);
		issue(op_put_full, 4'd2, 32'h8000_0008, 4'b1001, 32'h0bad_cafe);
		issue(op_get, 4'd2, 32'h8000_0008, 4'hf, 32'd0);
		issue(op_get, 4'd3, 32'h8000_0008, 4'hf, 32'd0);
		issue(op_get, 4'd4, 32'h8000_0000, 4'hf, 32'd0);
		a_valid <= 1'b0;
		while (expected.size() != 0) @(posedge clock);
		repeat (2) @(posedge clock);
		check_field("beat count", 32'(beat_count), 32'(expected_beats));
		$display("Checks done with %0d of %0d beats seen and %0d errors",
			beat_count, expected_beats, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (reset_cycles + hold_cycles + request_count * 40) @(posedge clock);
		$display("Watchdog expired with %0d responses still outstanding", expected.size());
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tl_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module tl_sequencer #(
	parameter int data_width = 32,
	parameter int ram_words  = 256
) (
	input  logic                         clock,
	input  logic                         int_reset,

	output logic                         a_ready,
	input  logic                         a_valid,
	input  tl_pkg::opcode_t              a_opcode,
	input  tl_pkg::size_t                a_size,
	input  tl_pkg::source_t              a_source,
	input  tl_pkg::addr_t                a_address,
	input  logic [data_width/8-1:0]      a_mask,
	input  logic [data_width-1:0]        a_data,

	input  logic                         d_ready,
	output logic                         d_valid,
	output tl_pkg::opcode_t              d_opcode,
	output tl_pkg::size_t                d_size,
	output tl_pkg::source_t              d_source,
	output logic                         d_denied,
	output logic                         d_corrupt,
	output logic [data_width-1:0]        d_data,

	output tl_pkg::addr_t                req_address,
	output tl_pkg::size_t                req_size,
	output logic                         req_write,
	input  logic                         allowed,
	input  logic                         in_ram,

	output logic                         ram_read,
	output logic                         ram_write,
	output logic [$clog2(ram_words)-1:0] ram_index,
	output logic [data_width-1:0]        ram_wdata,
	output logic [data_width/8-1:0]      ram_wmask,
	input  logic [data_width-1:0]        ram_rdata
);
	import tl_pkg::*;

	localparam int beat_bytes = data_width / 8;
	localparam int beat_log2  = $clog2(beat_bytes);
	localparam int index_w    = $clog2(ram_words);
	localparam int count_w    = 17;  // Up to 2^15 bytes plus a beat

	logic                  accept_en;
	logic                  busy;
	opcode_t               op_opcode;
	size_t                 op_size;
	source_t               op_source;
	addr_t                 op_address;
	logic [beat_bytes-1:0] op_mask;
	logic [data_width-1:0] op_data;
	logic [count_w-1:0]    count;
	logic [count_w-1:0]    next_count;
	logic                  last;
	logic                  a_fire;
	logic                  d_fire;
	logic                  put_write;
	logic [index_w-1:0]    op_index;
	logic [index_w-1:0]    read_index;
	logic                  pend;
	logic [index_w-1:0]    pend_index;
	logic [data_width-1:0] pend_data;
	logic [beat_bytes-1:0] pend_mask;
	logic                  fwd_hit;
	logic [data_width-1:0] read_word;

	assign req_address = op_address;
	assign req_size    = op_size;
	assign req_write   = op_opcode == op_put_full;

	assign op_index  = op_address[beat_log2 +: index_w];
	assign put_write = op_opcode == op_put_full && op_size <= size_t'(beat_log2)
		&& allowed && in_ram;

	assign d_valid = busy;
	assign d_fire  = d_valid && d_ready;
	assign a_ready = accept_en && (!busy || (last && d_fire));
	assign a_fire  = a_ready && a_valid;

	// Beat 0 is fetched on acceptance, later beats on each handshake
	assign ram_read   = (a_fire && a_opcode == op_get) || (d_fire && !last);
	assign read_index = a_fire ? a_address[beat_log2 +: index_w]
		: op_index + index_w'(next_count >> beat_log2);

	// Put data goes in during service or waits in pend behind a read
	assign ram_write = (pend || (busy && put_write)) && !ram_read;
	assign ram_index = ram_read ? read_index : pend ? pend_index : op_index;
	assign ram_wdata = pend ? pend_data : op_data;
	assign ram_wmask = pend ? pend_mask : op_mask;

	always_comb begin
		next_count = count + count_w'(beat_bytes);
		last       = 1'b1;
		d_opcode   = op_access_ack;
		d_denied   = 1'b1;  // Unsupported or oversized
		d_corrupt  = 1'b0;
		if (op_opcode == op_get) begin
			d_opcode  = op_access_ack_data;
			d_denied  = !allowed;
			d_corrupt = !allowed;
			if (allowed)
				last = next_count >= (count_w'(1) << op_size);
		end else if (op_opcode == op_put_full) begin
			d_denied = !(allowed && op_size <= size_t'(beat_log2));
		end
	end

	always_comb begin
		read_word = ram_rdata;
		if (fwd_hit) begin
			for (int b = 0; b < beat_bytes; b++) begin
				if (pend_mask[b])
					read_word[b*8 +: 8] = pend_data[b*8 +: 8];
			end
		end
	end

	assign d_data   = (op_opcode == op_get && allowed && in_ram) ? read_word : '0;
	assign d_size   = op_size;
	assign d_source = op_source;

	always_ff @(posedge clock) begin
		if (int_reset) begin
			accept_en <= 1'b0;
			busy      <= 1'b0;
			pend      <= 1'b0;
			fwd_hit   <= 1'b0;
		end else begin
			accept_en <= 1'b1;
			if (d_fire) begin
				count <= next_count;
				if (last)
					busy <= 1'b0;
			end
			if (a_fire) begin
				busy  <= 1'b1;
				count <= '0;
			end
			if (d_fire && put_write && ram_read)
				pend <= 1'b1;
			else if (ram_write)
				pend <= 1'b0;
			if (ram_read)  // Read hits a write not yet in the array
				fwd_hit <= (d_fire && put_write) ? read_index == op_index
					: pend && read_index == pend_index;
		end
	end

	always_ff @(posedge clock) begin
		if (a_fire) begin
			op_opcode  <= a_opcode;
			op_size    <= a_size;
			op_source  <= a_source;
			op_address <= a_address;
			op_mask    <= a_mask;
			op_data    <= a_data;
		end
		if (d_fire && put_write) begin
			pend_index <= op_index;
			pend_data  <= op_data;
			pend_mask  <= op_mask;
		end
	end

endmodule

`default_nettype wire
